//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= list.f
TB_TOP     ?= tb_load_unit
RTL_TOP    ?= load_unit
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
load_pkg.sv
load_dispatch.sv
load_slot.sv
load_mem_issue.sv
load_cdb_select.sv
load_unit.sv
tb_load_unit.sv

//--- load_cdb_select.sv
module load_cdb_select
    import load_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,
    input  logic [LOAD_DEPTH-1:0]        wants_cdb,
    input  load_entry_t [LOAD_DEPTH-1:0] entries,
    input  logic                         cdb_stall,
    output logic                         cdb_valid,
    output cdb_t                         cdb,
    output logic [LOAD_DEPTH-1:0]        cdb_accept
);

    logic [LOAD_DEPTH-1:0] lowest;
    logic [LOAD_DEPTH-1:0] sel;
    logic [LOAD_DEPTH-1:0] last_sel;
    logic                  stalled;

    assign lowest = wants_cdb & (~wants_cdb + 1'b1);

    // Keep presenting the stalled slot even if a lower slot finishes meanwhile.
    assign sel = (stalled && |(last_sel & wants_cdb)) ? last_sel : lowest;

    assign cdb_valid  = |sel;
    assign cdb_accept = cdb_stall ? '0 : sel;

    always_comb begin
        cdb = '0;
        for (int i = 0; i < LOAD_DEPTH; i++) begin
            if (sel[i]) begin
                cdb.tag    = entries[i].tag;
                cdb.result = entries[i].result;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            stalled <= 1'b0;
        end else begin
            stalled <= cdb_valid && cdb_stall;
        end
    end

    always_ff @(posedge clock) begin
        last_sel <= sel;
    end

endmodule

//--- load_dispatch.sv
module load_dispatch
    import load_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  dispatch_t             dispatch,
    input  logic [LOAD_DEPTH-1:0] slot_free,
    output logic [LOAD_DEPTH-1:0] alloc,
    output load_entry_t           new_entry,
    output logic                  full
);

    logic [LOAD_DEPTH-1:0] lowest_free;
    logic [ADDR_BITS-1:0]  offset_ext;

    // Sign-extend the 12-bit immediate.
    assign offset_ext = {{(ADDR_BITS-12){dispatch.offset[11]}}, dispatch.offset};

    always_comb begin
        new_entry          = '0;
        new_entry.addr     = dispatch.base + offset_ext;
        new_entry.size     = dispatch.size;
        new_entry.dest_reg = dispatch.dest_reg;
        new_entry.tag      = dispatch.tag;
        new_entry.br_mask  = dispatch.br_mask;
        new_entry.result   = '0;
    end

    // Lowest set bit of the free vector.
    assign lowest_free = slot_free & (~slot_free + 1'b1);

    assign alloc = dispatch_valid ? lowest_free : '0;

    // Full once nothing is left after this edge's claim.
    // Drops the cycle after some slot frees up.
    always_ff @(posedge clock) begin
        if (reset) begin
            full <= 1'b0;
        end else begin
            full <= ~|(slot_free & ~alloc);
        end
    end

endmodule

//--- load_input.txt
# D base offset funct3 dest tag br_mask expected_result (all hex)
# B task(1 squash, 2 clear) id | S stall cycles | M busy cycles | W idle cycles | E end
D 000010a0 000 0 05 01 0 fffffffa
D 000010b0 ff1 0 05 02 0 fffffffb
D 000010a0 002 0 06 03 0 fffffff8
D 000010a0 003 0 06 04 0 fffffff9
D 00001000 0a4 0 07 05 0 fffffffe
D 000010a0 005 0 07 06 0 ffffffff
D 000010a0 006 0 08 07 0 fffffffc
D 000010a8 fff 0 08 08 0 fffffffd
D 000010a0 000 4 09 09 0 000000fa
D 000010a0 001 4 09 0a 0 000000fb
D 000010a0 002 4 09 0b 0 000000f8
D 000010a0 003 4 09 0c 0 000000f9
D 000010a0 004 4 0a 0d 0 000000fe
D 000010a0 005 4 0a 0e 0 000000ff
D 000010a0 006 4 0a 0f 0 000000fc
D 000010a0 007 4 0a 10 0 000000fd
D 000010a0 000 1 0b 11 0 fffffbfa
D 000010a0 002 1 0b 12 0 fffff9f8
D 000010a0 004 1 0b 13 0 fffffffe
D 000010a0 006 1 0b 14 0 fffffdfc
D 000010a0 000 5 0c 15 0 0000fbfa
D 000010a0 002 5 0c 16 0 0000f9f8
D 000010a0 004 5 0c 17 0 0000fffe
D 000010a0 006 5 0c 18 0 0000fdfc
D 000010a0 000 2 0d 19 0 f9f8fbfa
D 000010a0 004 2 0d 1a 0 fdfcfffe
W 10
D 00003000 000 2 00 1b 0 00000000
D 00003100 010 0 00 1c 0 00000000
W 4
M 10
D 00002010 003 0 0e 1d 0 00000049
D 00002010 006 1 0e 1e 0 00004d4c
D 00002000 014 5 0e 1f 0 00004f4e
W 16
S 24
D 00006000 000 2 0f 00 0 59585b5a
D 00006000 004 2 0f 01 0 5d5c5f5e
D 00006000 001 0 0f 02 0 0000005b
D 00006000 007 4 0f 03 0 0000005d
D 00006008 002 1 0f 04 0 00005150
D 00006008 006 5 0f 05 0 00005554
W 30
S 12
D 00007000 000 2 10 06 1 59585b5a
W 2
M 12
D 00007100 000 2 10 07 1 59585b5a
D 00007200 004 2 11 08 2 5d5c5f5e
B 1 1
B 2 2
W 30
D 00008000 001 4 12 09 0 0000005b
D 00008000 006 1 12 0a 0 00005d5c
W 10
E

//--- load_mem_issue.sv
module load_mem_issue
    import load_pkg::*;
(
    input  logic [LOAD_DEPTH-1:0]        wants_issue,
    input  load_entry_t [LOAD_DEPTH-1:0] entries,
    input  logic                         mem_busy,
    output logic [LOAD_DEPTH-1:0]        issue_grant,
    output logic                         mem_start,
    output logic [ADDR_BITS-1:0]         mem_addr
);

    logic [LOAD_DEPTH-1:0] pick;

    // Fixed priority, slot 0 first.
    assign pick = wants_issue & (~wants_issue + 1'b1);

    assign issue_grant = mem_busy ? '0 : pick;
    assign mem_start   = |issue_grant;

    // One-hot mux of the winner's block address.
    always_comb begin
        mem_addr = '0;
        for (int i = 0; i < LOAD_DEPTH; i++) begin
            if (pick[i]) begin
                mem_addr = {entries[i].addr[ADDR_BITS-1:3], 3'b000};
            end
        end
    end

endmodule

//--- load_pkg.sv
package load_pkg;

    localparam int LOAD_DEPTH = 4;
    localparam int BR_BITS    = 4;
    localparam int TAG_BITS   = 5;
    localparam int ADDR_BITS  = 32;
    localparam int DATA_BITS  = 32;

    // One 64-bit memory block, indexed by the low address bits.
    typedef union packed {
        logic [7:0][7:0]  bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
    } mem_block_t;

    // Load funct3 encodings.
    // LW must be word-aligned and LH/LHU half-aligned.
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_size_e;

    typedef enum logic [1:0] {
        SLOT_FREE       = 2'd0,
        SLOT_WAIT_ISSUE = 2'd1,
        SLOT_WAIT_DATA  = 2'd2,
        SLOT_DONE       = 2'd3
    } slot_state_e;

    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_SQUASH = 2'd1,
        BR_CLEAR  = 2'd2
    } br_task_e;

    // Load as it leaves the reservation station.
    typedef struct packed {
        logic [DATA_BITS-1:0] base;
        logic [11:0]          offset;
        load_size_e           size;
        logic [4:0]           dest_reg;
        logic [TAG_BITS-1:0]  tag;
        logic [BR_BITS-1:0]   br_mask;
    } dispatch_t;

    // Load as held in a slot.
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        load_size_e           size;
        logic [4:0]           dest_reg;
        logic [TAG_BITS-1:0]  tag;
        logic [BR_BITS-1:0]   br_mask;
        logic [DATA_BITS-1:0] result;
    } load_entry_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]  tag;
        logic [DATA_BITS-1:0] result;
    } cdb_t;

endpackage

//--- load_slot.sv
module load_slot
    import load_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 alloc,
    input  load_entry_t          new_entry,
    input  br_task_e             br_task,
    input  logic [BR_BITS-1:0]   br_id,
    input  logic                 issue_grant,
    input  logic                 mem_data_valid,
    input  logic [ADDR_BITS-1:0] mem_block_addr,
    input  mem_block_t           mem_data,
    input  logic                 cdb_accept,
    output load_entry_t          entry,
    output logic                 wants_issue,
    output logic                 wants_cdb,
    output logic                 is_free
);

    slot_state_e          state;
    slot_state_e          next_state;
    load_entry_t          next_entry;
    logic [DATA_BITS-1:0] captured;
    logic                 block_hit;
    logic                 squash_hit;
    logic [7:0]           sel_byte;
    logic [15:0]          sel_half;

    assign block_hit = mem_block_addr[ADDR_BITS-1:3] == entry.addr[ADDR_BITS-1:3];

    // Squash of the load currently held.
    assign squash_hit = (br_task == BR_SQUASH) && |(entry.br_mask & br_id);

    assign sel_byte = mem_data.bytes[entry.addr[2:0]];
    assign sel_half = mem_data.halves[entry.addr[2:1]];

    // Pick the addressed part of the block and extend it.
    always_comb begin
        case (entry.size)
            LB:      captured = {{(DATA_BITS-8){sel_byte[7]}}, sel_byte};
            LBU:     captured = {{(DATA_BITS-8){1'b0}}, sel_byte};
            LH:      captured = {{(DATA_BITS-16){sel_half[15]}}, sel_half};
            LHU:     captured = {{(DATA_BITS-16){1'b0}}, sel_half};
            LW:      captured = mem_data.words[entry.addr[2]];
            default: captured = '0;
        endcase
    end

    always_comb begin
        next_state = state;
        next_entry = entry;

        if (alloc) begin
            next_entry = new_entry;
            next_state = SLOT_WAIT_ISSUE;
        end else begin
            case (state)
                SLOT_WAIT_ISSUE: begin
                    // x0 destination skips memory, result is already zero.
                    if (entry.dest_reg == 5'd0) begin
                        next_state = SLOT_DONE;
                    end else if (issue_grant) begin
                        next_state = SLOT_WAIT_DATA;
                    end
                end
                SLOT_WAIT_DATA: begin
                    if (mem_data_valid && block_hit) begin
                        next_entry.result = captured;
                        next_state        = SLOT_DONE;
                    end
                end
                SLOT_DONE: begin
                    if (cdb_accept) begin
                        next_state = SLOT_FREE;
                    end
                end
                default: begin
                    next_state = SLOT_FREE;
                end
            endcase
        end

        // Branch resolution wins over everything above.
        if (|(next_entry.br_mask & br_id)) begin
            if (br_task == BR_SQUASH) begin
                next_state = SLOT_FREE;
            end else if (br_task == BR_CLEAR) begin
                next_entry.br_mask = next_entry.br_mask & ~br_id;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= SLOT_FREE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        entry <= next_entry;
    end

    assign wants_issue = (state == SLOT_WAIT_ISSUE) && (entry.dest_reg != 5'd0) && !squash_hit;
    assign wants_cdb   = (state == SLOT_DONE) && !squash_hit;
    assign is_free     = state == SLOT_FREE;

endmodule

//--- load_unit.sv
module load_unit
    import load_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 dispatch_valid,
    input  dispatch_t            dispatch,
    input  br_task_e             br_task,
    input  logic [BR_BITS-1:0]   br_id,
    input  logic                 mem_busy,
    input  logic                 mem_data_valid,
    input  logic [ADDR_BITS-1:0] mem_block_addr,
    input  mem_block_t           mem_data,
    input  logic                 cdb_stall,
    output logic                 full,
    output logic                 mem_start,
    output logic [ADDR_BITS-1:0] mem_addr,
    output logic                 cdb_valid,
    output cdb_t                 cdb
);

    logic [LOAD_DEPTH-1:0]        alloc;
    load_entry_t                  new_entry;
    load_entry_t [LOAD_DEPTH-1:0] entries;
    logic [LOAD_DEPTH-1:0]        wants_issue;
    logic [LOAD_DEPTH-1:0]        wants_cdb;
    logic [LOAD_DEPTH-1:0]        slot_free;
    logic [LOAD_DEPTH-1:0]        issue_grant;
    logic [LOAD_DEPTH-1:0]        cdb_accept;

    load_dispatch i_load_dispatch (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .slot_free      (slot_free),
        .alloc          (alloc),
        .new_entry      (new_entry),
        .full           (full)
    );

    for (genvar i = 0; i < LOAD_DEPTH; i++) begin : g_slot
        load_slot i_load_slot (
            .clock          (clock),
            .reset          (reset),
            .alloc          (alloc[i]),
            .new_entry      (new_entry),
            .br_task        (br_task),
            .br_id          (br_id),
            .issue_grant    (issue_grant[i]),
            .mem_data_valid (mem_data_valid),
            .mem_block_addr (mem_block_addr),
            .mem_data       (mem_data),
            .cdb_accept     (cdb_accept[i]),
            .entry          (entries[i]),
            .wants_issue    (wants_issue[i]),
            .wants_cdb      (wants_cdb[i]),
            .is_free        (slot_free[i])
        );
    end

    load_mem_issue i_load_mem_issue (
        .wants_issue (wants_issue),
        .entries     (entries),
        .mem_busy    (mem_busy),
        .issue_grant (issue_grant),
        .mem_start   (mem_start),
        .mem_addr    (mem_addr)
    );

    load_cdb_select i_load_cdb_select (
        .clock      (clock),
        .reset      (reset),
        .wants_cdb  (wants_cdb),
        .entries    (entries),
        .cdb_stall  (cdb_stall),
        .cdb_valid  (cdb_valid),
        .cdb        (cdb),
        .cdb_accept (cdb_accept)
    );

endmodule

//--- tb_load_unit.sv
module tb_load_unit
    import load_pkg::*;
();

    logic                 clock;
    logic                 reset;
    logic                 dispatch_valid;
    dispatch_t            dispatch;
    br_task_e             br_task;
    logic [BR_BITS-1:0]   br_id;
    logic                 mem_busy;
    logic                 mem_data_valid;
    logic [ADDR_BITS-1:0] mem_block_addr;
    mem_block_t           mem_data;
    logic                 cdb_stall;
    logic                 full;
    logic                 mem_start;
    logic [ADDR_BITS-1:0] mem_addr;
    logic                 cdb_valid;
    cdb_t                 cdb;

    // Scoreboard entries indexed by tag.
    logic                 exp_valid  [2**TAG_BITS];
    logic [DATA_BITS-1:0] exp_result [2**TAG_BITS];
    logic [BR_BITS-1:0]   exp_mask   [2**TAG_BITS];
    logic [ADDR_BITS-4:0] exp_block  [2**TAG_BITS];
    logic [4:0]           exp_dest   [2**TAG_BITS];

    // Outstanding memory requests and the cycle each is answered in.
    logic [ADDR_BITS-1:0] req_block [$];
    int                   req_due [$];

    integer               seed;
    int                   cycle;
    int                   mismatches;
    int                   other_errors;
    int                   requests;
    int                   mem_loads;
    int                   busy_left;
    int                   stall_left;
    int                   held;
    int                   disp_now;
    int                   squash_now;
    logic                 expect_full;
    logic                 prev_hold;
    cdb_t                 prev_cdb;
    logic                 disp_pending;
    dispatch_t            disp_pkt;
    logic [DATA_BITS-1:0] disp_expect;
    logic                 br_pending;
    br_task_e             br_task_val;
    logic [BR_BITS-1:0]   br_id_val;
    string                lines [$];
    logic                 loaded;
    time                  limit;

    load_unit i_load_unit (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        wait (loaded);
        #(limit);
        $display("Timeout: the run did not finish within %0t time units", limit);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        $display("*** FAILED ***");
        $finish;
    end

    // Each byte of memory is the low address byte XOR 5a.
    function automatic mem_block_t block_data(input logic [ADDR_BITS-1:0] block_addr);
        mem_block_t           blk;
        logic [ADDR_BITS-1:0] a;
        for (int i = 0; i < 8; i++) begin
            a = block_addr + 32'(i);
            blk.bytes[i] = a[7:0] ^ 8'h5a;
        end
        return blk;
    endfunction

    function automatic logic block_needed(input logic [ADDR_BITS-4:0] block);
        for (int t = 0; t < 2**TAG_BITS; t++) begin
            if (exp_valid[t] && exp_dest[t] != 5'd0 && exp_block[t] == block) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        mismatches++;
        $display("Mismatch at time %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("Error at time %0t: %s", $time, msg);
    endtask

    // Drive on the falling edge and check one time unit later.
    task automatic run_cycle();
        int                   idx;
        int                   rnd;
        int                   delay;
        logic [ADDR_BITS-1:0] addr;
        logic                 merged;
        @(negedge clock);
        cycle++;
        dispatch_valid = 1'b0;
        br_task        = BR_NONE;
        br_id          = '0;
        mem_busy       = busy_left > 0;
        cdb_stall      = stall_left > 0;
        busy_left      = (busy_left > 0) ? busy_left - 1 : 0;
        stall_left     = (stall_left > 0) ? stall_left - 1 : 0;
        mem_data_valid = 1'b0;
        mem_block_addr = '0;
        mem_data       = '0;
        idx            = -1;
        for (int i = 0; i < req_due.size(); i++) begin
            if (idx < 0 && req_due[i] <= cycle) begin
                idx = i;
            end
        end
        if (idx >= 0) begin
            mem_data_valid = 1'b1;
            mem_block_addr = req_block[idx];
            mem_data       = block_data(req_block[idx]);
            req_block.delete(idx);
            req_due.delete(idx);
        end
        disp_now   = 0;
        squash_now = 0;
        // A tag is reused only after its earlier load has retired.
        if (disp_pending && !full && !exp_valid[disp_pkt.tag]) begin
            dispatch_valid = 1'b1;
            dispatch       = disp_pkt;
            addr = disp_pkt.base + {{(ADDR_BITS-12){disp_pkt.offset[11]}}, disp_pkt.offset};
            exp_valid[disp_pkt.tag]  = 1'b1;
            exp_result[disp_pkt.tag] = disp_expect;
            exp_mask[disp_pkt.tag]   = disp_pkt.br_mask;
            exp_block[disp_pkt.tag]  = addr[ADDR_BITS-1:3];
            exp_dest[disp_pkt.tag]   = disp_pkt.dest_reg;
            mem_loads    = mem_loads + ((disp_pkt.dest_reg != 5'd0) ? 1 : 0);
            disp_pending = 1'b0;
            disp_now     = 1;
        end
        if (br_pending) begin
            br_task = br_task_val;
            br_id   = br_id_val;
            for (int t = 0; t < 2**TAG_BITS; t++) begin
                if (exp_valid[t] && |(exp_mask[t] & br_id_val)) begin
                    if (br_task_val == BR_SQUASH) begin
                        exp_valid[t] = 1'b0;
                        squash_now++;
                    end else if (br_task_val == BR_CLEAR) begin
                        exp_mask[t] = exp_mask[t] & ~br_id_val;
                    end
                end
            end
            br_pending = 1'b0;
        end

        #1;
        // Full follows the occupancy at the previous edge including claims.
        if (full !== expect_full) begin
            report_mismatch("full", 64'(expect_full), 64'(full));
        end
        expect_full = (held + disp_now) == LOAD_DEPTH;
        if (mem_start) begin
            if (mem_busy) begin
                report_failure("memory request raised while memory is busy");
            end
            if (mem_addr[2:0] != 3'b000) begin
                report_mismatch("mem_addr[2:0]", 64'(0), 64'(mem_addr[2:0]));
            end
            if (!block_needed(mem_addr[ADDR_BITS-1:3])) begin
                report_failure($sformatf("request for block %h that no load needs", mem_addr));
            end
            requests++;
            merged = 1'b0;
            for (int i = 0; i < req_block.size(); i++) begin
                if (req_block[i] == {mem_addr[ADDR_BITS-1:3], 3'b000}) begin
                    merged = 1'b1;
                end
            end
            // A block with a reply already queued gets that one reply for all its loads.
            if (!merged) begin
                rnd   = $random(seed);
                delay = 1 + (rnd & 32'h7fffffff) % 6;
                req_block.push_back({mem_addr[ADDR_BITS-1:3], 3'b000});
                req_due.push_back(cycle + delay);
            end
        end
        if (prev_hold && squash_now == 0) begin
            if (!cdb_valid) begin
                report_failure("cdb_valid dropped while the CDB was stalled");
            end else if (cdb !== prev_cdb) begin
                report_mismatch("cdb", 64'(prev_cdb), 64'(cdb));
            end
        end
        if (cdb_valid && !cdb_stall) begin
            if (!exp_valid[cdb.tag]) begin
                report_failure($sformatf("tag %0d broadcast with no load outstanding", cdb.tag));
            end else begin
                if (cdb.result !== exp_result[cdb.tag]) begin
                    report_mismatch("cdb.result", 64'(exp_result[cdb.tag]), 64'(cdb.result));
                end
                exp_valid[cdb.tag] = 1'b0;
                held--;
            end
        end
        held      = held + disp_now - squash_now;
        prev_hold = cdb_valid && cdb_stall;
        prev_cdb  = cdb;
    endtask

    initial begin
        integer               fd;
        int                   n;
        int                   count;
        string                text;
        logic [7:0]           cmd;
        logic [31:0]          base;
        logic [11:0]          offset;
        logic [2:0]           size_bits;
        logic [4:0]           dest;
        logic [4:0]           tag;
        logic [3:0]           mask;
        logic [31:0]          result_val;
        logic [1:0]           task_bits;
        logic                 finished;
        seed           = 32'hc33;
        loaded         = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        br_task        = BR_NONE;
        br_id          = '0;
        mem_busy       = 1'b0;
        mem_data_valid = 1'b0;
        mem_block_addr = '0;
        mem_data       = '0;
        cdb_stall      = 1'b0;
        cycle          = 0;
        mismatches     = 0;
        other_errors   = 0;
        requests       = 0;
        mem_loads      = 0;
        busy_left      = 0;
        stall_left     = 0;
        held           = 0;
        disp_now       = 0;
        squash_now     = 0;
        expect_full    = 1'b0;
        prev_hold      = 1'b0;
        disp_pending   = 1'b0;
        br_pending     = 1'b0;
        finished       = 1'b0;
        prev_cdb       = '0;
        for (int t = 0; t < 2**TAG_BITS; t++) begin
            exp_valid[t] = 1'b0;
        end
        fd = $fopen("load_input.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open load_input.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                if (n > 0) begin
                    lines.push_back(text);
                end
            end
            $fclose(fd);
        end
        // Allow 200 cycles of four time units for each line.
        limit  = (lines.size() + 1) * 200 * 4;
        loaded = 1'b1;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int i = 0; i < lines.size() && !finished; i++) begin
            text = lines[i];
            if (text.len() < 1 || text.getc(0) == "#" || text.getc(0) == "\n") begin
                continue;
            end
            n = $sscanf(text, "%c", cmd);
            case (cmd)
                "D": begin
                    n = $sscanf(text, "%c %h %h %h %h %h %h %h", cmd, base, offset,
                                size_bits, dest, tag, mask, result_val);
                    disp_pkt     = '{base, offset, load_size_e'(size_bits), dest, tag, mask};
                    disp_expect  = result_val;
                    disp_pending = (n == 8);
                    if (n != 8) begin
                        report_failure($sformatf("malformed dispatch line: %s", text));
                    end
                    while (disp_pending) begin
                        run_cycle();
                    end
                end
                "B": begin
                    n = $sscanf(text, "%c %h %h", cmd, task_bits, br_id_val);
                    br_task_val = br_task_e'(task_bits);
                    br_pending  = 1'b1;
                    run_cycle();
                end
                "S", "M", "W": begin
                    n = $sscanf(text, "%c %d", cmd, count);
                    if (cmd == "S") begin
                        stall_left = count;
                    end else if (cmd == "M") begin
                        busy_left = count;
                    end else begin
                        repeat (count) run_cycle();
                    end
                end
                "E": begin
                    while (held != 0 || req_block.size() != 0) begin
                        run_cycle();
                    end
                    repeat (4) run_cycle();
                    finished = 1'b1;
                end
                default: begin
                    report_failure($sformatf("unknown command in line: %s", text));
                end
            endcase
        end

        if (requests > mem_loads) begin
            report_failure("more memory requests than loads that need memory");
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
